// ==== include/csr_cfg.svh ====
// rv32 machine mode only and no hpm counters, so misa and the inhibit force bits are fixed here
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

`define CSR_XLEN          32  // data word
`define CSR_CNT_W         64  // mcycle / minstret
`define CSR_CORE_ID_W     4
`define CSR_CLUSTER_ID_W  6

//////////////////////////////////////////////////
// fixed register contents
//////////////////////////////////////////////////

// mxl=1 (rv32) at 31:30, i at bit 8, c at bit 2, m left off
`define CSR_MISA_VALUE    32'h4000_0104

// hpm counters 3..31 absent, their inhibit bits read one
`define CSR_INHIBIT_FORCE 32'hffff_fff8

// mstatus field positions
`define CSR_MSTATUS_MIE_BIT   3
`define CSR_MSTATUS_MPIE_BIT  7

`endif

// ==== hw/csr_pkg.sv ====
// shared csr types for machine mode only, widths come from the cfg header
`include "csr_cfg.svh"

package csr_pkg;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // supported addresses, anything else is illegal
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MCYCLE        = 12'hb00,
    CSR_MINSTRET      = 12'hb02,
    CSR_MCYCLEH       = 12'hb80,
    CSR_MINSTRETH     = 12'hb82,
    CSR_MHARTID       = 12'hf14
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11  // the only level ever held
  } priv_lvl_e;

  // address split per privileged spec
  typedef struct packed {
    logic [1:0] rw;   // 2'b11 marks read-only space
    priv_lvl_e  priv; // lowest level allowed to access
    logic [7:0] idx;
  } csr_addr_fields_t;

  // same 12 bits, matched as enum or split into fields
  typedef union packed {
    csr_num_e         num;
    csr_addr_fields_t fields;
  } csr_addr_u;

  //////////////////////////////////////////////////
  // register and transfer structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  typedef struct packed {
    logic       irq;  // read back at bit xlen-1
    logic [4:0] code;
  } mcause_t;

  // decoder -> state and counters
  typedef struct packed {
    logic [`CSR_XLEN-1:0] wdata; // after set / clear
    logic                 we_mstatus;
    logic                 we_mepc;
    logic                 we_mcause;
    logic                 we_mtval;
    logic                 we_mcountinhibit;
    logic                 we_mcycle;
    logic                 we_mcycleh;
    logic                 we_minstret;
    logic                 we_minstreth;
  } csr_wr_t;

  // core -> trap state
  typedef struct packed {
    logic                 save_cause;
    logic                 mret;
    logic [`CSR_XLEN-1:0] pc;
    mcause_t              mcause;
    logic [`CSR_XLEN-1:0] mtval;
  } trap_req_t;

  typedef struct packed {
    mstatus_t             mstatus;
    logic [`CSR_XLEN-1:0] mepc;
    mcause_t              mcause;
    logic [`CSR_XLEN-1:0] mtval;
  } trap_view_t;

  typedef struct packed {
    logic [`CSR_CNT_W-1:0] mcycle;
    logic [`CSR_CNT_W-1:0] minstret;
    logic [`CSR_XLEN-1:0]  mcountinhibit; // forced bits already merged
  } cnt_view_t;

endpackage

// ==== hw/csr_access_decode.sv ====
// single-cycle access with no back-pressure, and illegal accesses still reach the write path
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_access_decode (
  input  logic                         csr_access_i,
  input  logic                         is_decoding_i,   // commit qualifier
  input  csr_pkg::csr_num_e            csr_addr_i,
  input  csr_pkg::csr_op_e             csr_op_i,
  input  logic [`CSR_XLEN-1:0]         csr_wdata_i,
  input  logic [`CSR_CORE_ID_W-1:0]    core_id_i,
  input  logic [`CSR_CLUSTER_ID_W-1:0] cluster_id_i,
  input  csr_pkg::trap_view_t          trap_view_i,
  input  csr_pkg::cnt_view_t           cnt_view_i,
  output logic [`CSR_XLEN-1:0]         csr_rdata_o,     // value before update
  output logic                         illegal_csr_insn_o,
  output csr_pkg::csr_wr_t             csr_wr_o
);

  import csr_pkg::*;

  localparam int unsigned HartPad = `CSR_XLEN - `CSR_CLUSTER_ID_W - `CSR_CORE_ID_W - 1;

  csr_addr_u            addr;         // enum and field view
  logic [`CSR_XLEN-1:0] rdata;
  logic [`CSR_XLEN-1:0] wdata;        // after set / clear
  logic                 wreq;         // op is not a read
  logic                 we;           // committing write
  logic                 unknown_addr;
  logic                 ro_write;     // write into read-only space

  always_comb begin
    addr.num = csr_addr_i;
  end

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////

  always_comb begin
    rdata        = '0;
    unknown_addr = 1'b0;
    unique case (addr.num)
      CSR_MHARTID: rdata = {{HartPad{1'b0}}, cluster_id_i, 1'b0, core_id_i};
      CSR_MISA:    rdata = `CSR_MISA_VALUE;
      CSR_MSTATUS: begin
        rdata[`CSR_MSTATUS_MIE_BIT]  = trap_view_i.mstatus.mie;
        rdata[`CSR_MSTATUS_MPIE_BIT] = trap_view_i.mstatus.mpie;
      end
      CSR_MEPC:    rdata = trap_view_i.mepc;
      CSR_MCAUSE: begin
        rdata[`CSR_XLEN-1] = trap_view_i.mcause.irq; // interrupt flag on top
        rdata[4:0]         = trap_view_i.mcause.code;
      end
      CSR_MTVAL:         rdata = trap_view_i.mtval;
      CSR_MCOUNTINHIBIT: rdata = cnt_view_i.mcountinhibit;
      // counters split into halves
      CSR_MCYCLE:    rdata = cnt_view_i.mcycle[`CSR_XLEN-1:0];
      CSR_MCYCLEH:   rdata = cnt_view_i.mcycle[`CSR_CNT_W-1:`CSR_XLEN];
      CSR_MINSTRET:  rdata = cnt_view_i.minstret[`CSR_XLEN-1:0];
      CSR_MINSTRETH: rdata = cnt_view_i.minstret[`CSR_CNT_W-1:`CSR_XLEN];
      default:       unknown_addr = 1'b1; // no such register
    endcase
  end

  //////////////////////////////////////////////////
  // operation
  //////////////////////////////////////////////////

  always_comb begin
    wdata = csr_wdata_i;
    wreq  = 1'b1;
    unique case (csr_op_i)
      CSR_OP_WRITE: wdata = csr_wdata_i;
      CSR_OP_SET:   wdata = rdata | csr_wdata_i;
      CSR_OP_CLEAR: wdata = rdata & ~csr_wdata_i;
      CSR_OP_READ:  wreq  = 1'b0;   // data ignored
    endcase
  end

  assign we       = wreq & is_decoding_i;        // one cycle only
  assign ro_write = (addr.fields.rw == 2'b11) & wreq;

  // flag only while an access is presented
  assign illegal_csr_insn_o = csr_access_i & (unknown_addr | ro_write);
  assign csr_rdata_o        = rdata;

  //////////////////////////////////////////////////
  // write strobes
  //////////////////////////////////////////////////

  always_comb begin
    csr_wr_o       = '0;
    csr_wr_o.wdata = wdata;
    unique case (addr.num)
      CSR_MSTATUS:       csr_wr_o.we_mstatus       = we;
      CSR_MEPC:          csr_wr_o.we_mepc          = we;
      CSR_MCAUSE:        csr_wr_o.we_mcause        = we;
      CSR_MTVAL:         csr_wr_o.we_mtval         = we;
      CSR_MCOUNTINHIBIT: csr_wr_o.we_mcountinhibit = we;
      CSR_MCYCLE:        csr_wr_o.we_mcycle        = we;
      CSR_MCYCLEH:       csr_wr_o.we_mcycleh       = we;
      CSR_MINSTRET:      csr_wr_o.we_minstret      = we;
      CSR_MINSTRETH:     csr_wr_o.we_minstreth     = we;
      default: ;  // mhartid, misa and unknown have nothing to write
    endcase
  end

endmodule

// ==== hw/csr_trap_state.sv ====
// machine mode trap registers only, save beats mret and both beat a same-cycle software write
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_trap_state (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  csr_pkg::csr_wr_t     csr_wr_i,
  input  csr_pkg::trap_req_t   trap_req_i,
  output csr_pkg::trap_view_t  trap_view_o,
  output logic                 m_irq_enable_o,
  output logic [`CSR_XLEN-1:0] csr_mepc_o
);

  import csr_pkg::*;

  mstatus_t             mstatus_q, mstatus_d;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_d;
  mcause_t              mcause_q, mcause_d;
  logic [`CSR_XLEN-1:0] mtval_q, mtval_d;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;
    mtval_d   = mtval_q;

    // software writes first
    if (csr_wr_i.we_mstatus) begin
      mstatus_d.mie  = csr_wr_i.wdata[`CSR_MSTATUS_MIE_BIT];
      mstatus_d.mpie = csr_wr_i.wdata[`CSR_MSTATUS_MPIE_BIT];
    end
    if (csr_wr_i.we_mepc) begin
      mepc_d = csr_wr_i.wdata;
    end
    if (csr_wr_i.we_mcause) begin
      mcause_d.irq  = csr_wr_i.wdata[`CSR_XLEN-1];
      mcause_d.code = csr_wr_i.wdata[4:0];
    end
    if (csr_wr_i.we_mtval) begin
      mtval_d = csr_wr_i.wdata;
    end

    // trap controller overrides
    if (trap_req_i.save_cause) begin
      mstatus_d.mpie = mstatus_q.mie;   // stack the enable
      mstatus_d.mie  = 1'b0;            // enter handler masked
      mepc_d         = trap_req_i.pc;
      mcause_d       = trap_req_i.mcause;
      mtval_d        = trap_req_i.mtval;
    end else if (trap_req_i.mret) begin
      mstatus_d.mie  = mstatus_q.mpie;  // pop
      mstatus_d.mpie = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
      mtval_q   <= mtval_d;
    end
  end

  // straight from the flops
  assign trap_view_o.mstatus = mstatus_q;
  assign trap_view_o.mepc    = mepc_q;
  assign trap_view_o.mcause  = mcause_q;
  assign trap_view_o.mtval   = mtval_q;

  assign m_irq_enable_o = mstatus_q.mie;
  assign csr_mepc_o     = mepc_q;

endmodule

// ==== hw/csr_counters.sv ====
// mcycle and minstret only, inhibit takes effect the cycle after it is written
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_counters (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  csr_pkg::csr_wr_t   csr_wr_i,
  input  logic               insn_ret_i,  // one pulse per retired insn
  output csr_pkg::cnt_view_t cnt_view_o
);

  import csr_pkg::*;

  logic [`CSR_CNT_W-1:0] mcycle_q, mcycle_d;
  logic [`CSR_CNT_W-1:0] minstret_q, minstret_d;
  logic                  inh_cy_q;   // mcountinhibit bit 0
  logic                  inh_ir_q;   // mcountinhibit bit 2
  logic                  cy_inc;
  logic                  ir_inc;

  // half writes win over increment
  function automatic logic [`CSR_CNT_W-1:0] cnt_next(
    input logic [`CSR_CNT_W-1:0] q,
    input logic                  inc,
    input logic                  we_lo,
    input logic                  we_hi,
    input logic [`CSR_XLEN-1:0]  wdata
  );
    logic [`CSR_CNT_W-1:0] n;
    n = q;
    if (we_lo) begin
      n[`CSR_XLEN-1:0] = wdata;
    end else if (we_hi) begin
      n[`CSR_CNT_W-1:`CSR_XLEN] = wdata;
    end else if (inc) begin
      n = q + 1'b1;  // wraps at 2^64
    end
    return n;
  endfunction

  //////////////////////////////////////////////////
  // increment and update
  //////////////////////////////////////////////////

  assign cy_inc = ~inh_cy_q;               // every cycle
  assign ir_inc = insn_ret_i & ~inh_ir_q;

  assign mcycle_d   = cnt_next(mcycle_q, cy_inc, csr_wr_i.we_mcycle,
                               csr_wr_i.we_mcycleh, csr_wr_i.wdata);
  assign minstret_d = cnt_next(minstret_q, ir_inc, csr_wr_i.we_minstret,
                               csr_wr_i.we_minstreth, csr_wr_i.wdata);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
      inh_cy_q   <= 1'b0;
      inh_ir_q   <= 1'b0;
    end else begin
      mcycle_q   <= mcycle_d;
      minstret_q <= minstret_d;
      if (csr_wr_i.we_mcountinhibit) begin
        inh_cy_q <= csr_wr_i.wdata[0];
        inh_ir_q <= csr_wr_i.wdata[2];   // bit 1 has no counter
      end
    end
  end

  // read view, bit 1 zero and absent hpm bits forced high
  assign cnt_view_o.mcycle        = mcycle_q;
  assign cnt_view_o.minstret      = minstret_q;
  assign cnt_view_o.mcountinhibit = `CSR_INHIBIT_FORCE |
                                    {{(`CSR_XLEN-3){1'b0}}, inh_ir_q, 1'b0, inh_cy_q};

endmodule

// ==== hw/csr_top.sv ====
// machine mode csr block with one-cycle sram-like access and trap pc handed over by the core
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // hart identity
  input  logic [`CSR_CORE_ID_W-1:0]    core_id_i,
  input  logic [`CSR_CLUSTER_ID_W-1:0] cluster_id_i,
  // access port
  input  logic                         csr_access_i,
  input  logic                         is_decoding_i,
  input  csr_pkg::csr_num_e            csr_addr_i,
  input  csr_pkg::csr_op_e             csr_op_i,
  input  logic [`CSR_XLEN-1:0]         csr_wdata_i,
  output logic [`CSR_XLEN-1:0]         csr_rdata_o,
  output logic                         illegal_csr_insn_o,
  // trap port
  input  csr_pkg::trap_req_t           trap_req_i,
  output logic                         m_irq_enable_o,
  output logic [`CSR_XLEN-1:0]         csr_mepc_o,
  // events
  input  logic                         insn_ret_i
);

  import csr_pkg::*;

  csr_wr_t    csr_wr;     // decoder -> both holders
  trap_view_t trap_view;
  cnt_view_t  cnt_view;

  csr_access_decode u_decode (
    .csr_access_i       (csr_access_i),
    .is_decoding_i      (is_decoding_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_wdata_i        (csr_wdata_i),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .trap_view_i        (trap_view),
    .cnt_view_i         (cnt_view),
    .csr_rdata_o        (csr_rdata_o),
    .illegal_csr_insn_o (illegal_csr_insn_o),
    .csr_wr_o           (csr_wr)
  );

  csr_trap_state u_trap_state (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .csr_wr_i       (csr_wr),
    .trap_req_i     (trap_req_i),
    .trap_view_o    (trap_view),
    .m_irq_enable_o (m_irq_enable_o),
    .csr_mepc_o     (csr_mepc_o)
  );

  csr_counters u_counters (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .csr_wr_i   (csr_wr),
    .insn_ret_i (insn_ret_i),
    .cnt_view_o (cnt_view)
  );

endmodule

// ==== test/csr_top_tb.sv ====
// the model starts at reset and expects one access per cycle with no back-pressure
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_top_tb;

  import csr_pkg::*;

  localparam int RMW_OPS    = 200;
  localparam int TEST_LEN   = 8 + 2 * RMW_OPS + 20 + 30 + 140; // reset, rmw, trap, illegal, counters
  localparam int MAX_CYCLES = 2 * TEST_LEN;

  logic                         clk_i;
  logic                         rst_ni;
  logic [`CSR_CORE_ID_W-1:0]    core_id;
  logic [`CSR_CLUSTER_ID_W-1:0] cluster_id;
  logic                         csr_access, is_decoding, insn_ret;
  csr_num_e                     csr_addr;
  csr_op_e                      csr_op;
  logic [`CSR_XLEN-1:0]         csr_wdata, csr_rdata, csr_mepc;
  logic                         illegal_csr, m_irq_enable;
  trap_req_t                    trap_req;

  integer seed = 66571;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  logic [`CSR_XLEN-1:0] exp_rdata;
  logic                 exp_ill;

  // reference state of the architectural registers
  logic                  m_mie, m_mpie, m_irq, m_inh_cy, m_inh_ir;
  logic [4:0]            m_code;
  logic [`CSR_XLEN-1:0]  m_mepc, m_mtval;
  logic [`CSR_CNT_W-1:0] m_mcycle, m_minstret;

  csr_top dut0 (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .core_id_i          (core_id),
    .cluster_id_i       (cluster_id),
    .csr_access_i       (csr_access),
    .is_decoding_i      (is_decoding),
    .csr_addr_i         (csr_addr),
    .csr_op_i           (csr_op),
    .csr_wdata_i        (csr_wdata),
    .csr_rdata_o        (csr_rdata),
    .illegal_csr_insn_o (illegal_csr),
    .trap_req_i         (trap_req),
    .m_irq_enable_o     (m_irq_enable),
    .csr_mepc_o         (csr_mepc),
    .insn_ret_i         (insn_ret)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // expected read word and flag for the access on the port right now
  function automatic void ref_csr(output logic [31:0] rd, output logic ill);
    logic [11:0] a;
    logic        unknown;
    a       = csr_addr;
    rd      = '0;
    unknown = 1'b0;
    case (a)
      12'hf14: begin
        rd[3:0]  = core_id;     // bit 4 left zero
        rd[10:5] = cluster_id;
      end
      12'h301: rd = (32'h1 << 30) | (32'h1 << 8) | (32'h1 << 2); // rv32 with i and c
      12'h300: rd = {24'b0, m_mpie, 3'b0, m_mie, 3'b0};
      12'h341: rd = m_mepc;
      12'h342: rd = {m_irq, 26'b0, m_code};
      12'h343: rd = m_mtval;
      12'h320: rd = 32'hffff_fff8 | {29'b0, m_inh_ir, 1'b0, m_inh_cy};
      12'hb00: rd = m_mcycle[31:0];
      12'hb80: rd = m_mcycle[63:32];
      12'hb02: rd = m_minstret[31:0];
      12'hb82: rd = m_minstret[63:32];
      default: unknown = 1'b1;
    endcase
    // 2'b11 in the top bits is read-only space
    ill = csr_access & (unknown | ((a[11:10] == 2'b11) & (csr_op != CSR_OP_READ)));
  endfunction

  // state after the coming edge
  function automatic void advance_model(input logic [31:0] rd);
    logic [31:0] wd;
    logic        we, inc_cy, inc_ir, old_mie, old_mpie;
    logic [11:0] a;
    a        = csr_addr;
    old_mie  = m_mie;
    old_mpie = m_mpie;
    case (csr_op)
      CSR_OP_SET:   wd = rd | csr_wdata;
      CSR_OP_CLEAR: wd = rd & ~csr_wdata;
      default:      wd = csr_wdata;
    endcase
    we     = (csr_op != CSR_OP_READ) & is_decoding;
    inc_cy = ~m_inh_cy;            // inhibit as stored before this edge
    inc_ir = insn_ret & ~m_inh_ir;
    if (we) begin
      case (a)
        12'h300: {m_mpie, m_mie} = {wd[7], wd[3]};
        12'h341: m_mepc = wd;
        12'h342: {m_irq, m_code} = {wd[31], wd[4:0]};
        12'h343: m_mtval = wd;
        12'h320: {m_inh_ir, m_inh_cy} = {wd[2], wd[0]};
        12'hb00: begin
          m_mcycle[31:0] = wd;
          inc_cy         = 1'b0;
        end
        12'hb80: begin
          m_mcycle[63:32] = wd;
          inc_cy          = 1'b0;
        end
        12'hb02: begin
          m_minstret[31:0] = wd;
          inc_ir           = 1'b0;
        end
        12'hb82: begin
          m_minstret[63:32] = wd;
          inc_ir            = 1'b0;
        end
        default: ;
      endcase
    end
    if (trap_req.save_cause) begin  // save beats mret and software
      m_mpie = old_mie;
      m_mie  = 1'b0;
      m_mepc = trap_req.pc;
      {m_irq, m_code} = trap_req.mcause;
      m_mtval = trap_req.mtval;
    end else if (trap_req.mret) begin
      m_mie  = old_mpie;
      m_mpie = 1'b1;
    end
    if (inc_cy) m_mcycle = m_mcycle + 1;
    if (inc_ir) m_minstret = m_minstret + 1;
  endfunction

  function automatic void reset_model();
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_irq      = 1'b0;
    m_inh_cy   = 1'b0;
    m_inh_ir   = 1'b0;
    m_code     = '0;
    m_mepc     = '0;
    m_mtval    = '0;
    m_mcycle   = '0;
    m_minstret = '0;
  endfunction

  //////////////////////////////////////////////////
  // compare mid-cycle where outputs are settled
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni !== 1'b1) begin
      reset_model();
    end else begin
      ref_csr(exp_rdata, exp_ill);
      checks = checks + 1;
      if (csr_access && csr_rdata !== exp_rdata) begin
        errors = errors + 1;
        $display("Error: csr_rdata_o addr=%h got %h expected %h", csr_addr, csr_rdata, exp_rdata);
      end
      if (illegal_csr !== exp_ill) begin
        errors = errors + 1;
        $display("Error: illegal_csr_insn_o addr=%h got %h expected %h", csr_addr, illegal_csr,
                 exp_ill);
      end
      if (m_irq_enable !== m_mie) begin
        errors = errors + 1;
        $display("Error: m_irq_enable_o got %h expected %h", m_irq_enable, m_mie);
      end
      if (csr_mepc !== m_mepc) begin
        errors = errors + 1;
        $display("Error: csr_mepc_o got %h expected %h", csr_mepc, m_mepc);
      end
      advance_model(exp_rdata);
    end
  end

  initial begin
    forever begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic access_csr(input logic [11:0] a, input logic [1:0] op, input logic [31:0] d,
                            input logic dec);
    csr_access  = 1'b1;
    csr_addr    = csr_num_e'(a);
    csr_op      = csr_op_e'(op);
    csr_wdata   = d;
    is_decoding = dec;
    step();
  endtask

  task automatic read_csr(input logic [11:0] a);
    access_csr(a, CSR_OP_READ, 32'h0, 1'b1);
  endtask

  initial begin
    csr_num_e    walk;
    logic [11:0] a;
    rst_ni      = 1'b0;
    csr_access  = 1'b0;
    is_decoding = 1'b0;
    insn_ret    = 1'b0;
    csr_wdata   = '0;
    csr_addr    = CSR_MSTATUS;
    csr_op      = CSR_OP_READ;
    trap_req    = '0;
    core_id     = 4'h5;
    cluster_id  = 6'h2a;
    repeat (4) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    // reset values and identity
    read_csr(CSR_MSTATUS);
    read_csr(CSR_MEPC);
    read_csr(CSR_MCAUSE);
    read_csr(CSR_MTVAL);
    read_csr(CSR_MHARTID);
    read_csr(CSR_MISA);

    // random read-modify-write, some not committed
    for (int i = 0; i < RMW_OPS; i++) begin
      case ({$random(seed)} % 4)
        0:       a = CSR_MSTATUS;
        1:       a = CSR_MEPC;
        2:       a = CSR_MCAUSE;
        default: a = CSR_MTVAL;
      endcase
      access_csr(a, 2'({$random(seed)} % 4), $random(seed), ({$random(seed)} % 4) != 0);
      read_csr(a);
    end

    // trap save against a same-cycle mepc write, then mret
    access_csr(CSR_MSTATUS, CSR_OP_WRITE, 32'h8, 1'b1);
    trap_req = '{save_cause: 1'b1, mret: 1'b0, pc: $random(seed), mcause: 6'h2b,
                 mtval: $random(seed)};
    access_csr(CSR_MEPC, CSR_OP_WRITE, $random(seed), 1'b1);
    trap_req = '0;
    read_csr(CSR_MEPC);
    read_csr(CSR_MCAUSE);
    read_csr(CSR_MTVAL);
    read_csr(CSR_MSTATUS);
    trap_req.mret = 1'b1;
    read_csr(CSR_MSTATUS);
    trap_req = '0;
    read_csr(CSR_MSTATUS);
    trap_req = '{save_cause: 1'b1, mret: 1'b1, pc: 32'h100, mcause: 6'h03, mtval: 32'h0};
    read_csr(CSR_MSTATUS);
    trap_req = '0;
    read_csr(CSR_MSTATUS);
    read_csr(CSR_MEPC);

    // illegal flag
    for (int i = 0; i < 4; i++) begin
      a = (i == 0) ? 12'h305 : (i == 1) ? 12'h7b0 : (i == 2) ? 12'h000 : 12'hb03;
      read_csr(a);
      access_csr(a, CSR_OP_WRITE, $random(seed), 1'b1);
    end
    for (int op = 1; op < 4; op++) access_csr(CSR_MHARTID, 2'(op), $random(seed), 1'b1);
    read_csr(CSR_MHARTID);
    csr_access = 1'b0;    // flag must stay low with no access
    csr_addr   = csr_num_e'(12'h7b0);
    csr_op     = CSR_OP_WRITE;
    step();
    walk = walk.first();
    repeat (walk.num()) begin
      read_csr(walk);
      walk = walk.next();
    end

    // counters and inhibit
    repeat (20) read_csr(CSR_MCYCLE);
    repeat (40) begin
      insn_ret = 1'($random(seed));
      read_csr(CSR_MINSTRET);
    end
    insn_ret = 1'b0;
    access_csr(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h1, 1'b1);
    repeat (10) read_csr(CSR_MCYCLE);
    read_csr(CSR_MCOUNTINHIBIT);
    access_csr(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h4, 1'b1);
    repeat (30) begin
      insn_ret = 1'($random(seed));
      read_csr(CSR_MINSTRET);
    end
    insn_ret = 1'b0;
    access_csr(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'hffff_ffff, 1'b1);
    read_csr(CSR_MCOUNTINHIBIT);
    access_csr(CSR_MCOUNTINHIBIT, CSR_OP_CLEAR, 32'hffff_ffff, 1'b1);
    access_csr(CSR_MCYCLE, CSR_OP_WRITE, $random(seed), 1'b1);
    access_csr(CSR_MCYCLEH, CSR_OP_WRITE, $random(seed), 1'b1);
    access_csr(CSR_MINSTRET, CSR_OP_WRITE, $random(seed), 1'b1);
    access_csr(CSR_MINSTRETH, CSR_OP_WRITE, $random(seed), 1'b1);
    read_csr(CSR_MCYCLEH);
    read_csr(CSR_MINSTRET);
    read_csr(CSR_MINSTRETH);
    access_csr(CSR_MCYCLE, CSR_OP_WRITE, 32'hffff_fffd, 1'b1);  // carry into the high half
    repeat (3) begin
      read_csr(CSR_MCYCLE);
      read_csr(CSR_MCYCLEH);
    end

    csr_access = 1'b0;
    csr_op     = CSR_OP_READ;
    is_decoding = 1'b0;
    step();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== csr_top.f ====
+incdir+include
hw/csr_pkg.sv
hw/csr_access_decode.sv
hw/csr_trap_state.sv
hw/csr_counters.sv
hw/csr_top.sv
test/csr_top_tb.sv

// ==== Bender.yml ====
package:
  name: csr_top

export_include_dirs:
  - include

sources:
  - hw/csr_pkg.sv
  - hw/csr_access_decode.sv
  - hw/csr_trap_state.sv
  - hw/csr_counters.sv
  - hw/csr_top.sv
  - target: test
    files:
      - test/csr_top_tb.sv
